/* design/msx_mapper_cfg.svh */
// Cartridge mapper widths
`ifndef MSX_MAPPER_CFG_SVH
`define MSX_MAPPER_CFG_SVH

// Width of the linear ROM/RAM address on the memory side
// 27 bits cover a 128 MB linear space
`define MAPPER_ADDR_W 27

// CPU address bus width of the Z80 side
`define MAPPER_CPU_ADDR_W 16

// CPU data bus width
`define MAPPER_CPU_DATA_W 8

// Width of the ROM size field in bytes
// Two bits narrower than the linear address, so it is zero extended for the size check
`define MAPPER_ROM_SIZE_W 25

// Number of cartridge blocks
// Every mapper keeps its bank state once per block
`define MAPPER_BLOCKS 2

`endif

/* design/msx_mapper_pkg.sv */
// Cartridge mapper types
`default_nettype none

`include "msx_mapper_cfg.svh"

package msx_mapper_pkg;

    // Mapper kind stored per cartridge block
    // MAPPER_NONE leaves the block unmapped, so every read gives ram_cs low
    typedef enum logic [1:0] {
        MAPPER_NONE      = 2'd0,
        // Flat ROM from 4000h with no bank registers
        MAPPER_PLAIN     = 2'd1,
        // Two 16 KB windows with 8-bit bank registers
        MAPPER_ASCII16   = 2'd2,
        // Two 32 KB granular windows with a 1-bit bank register each
        MAPPER_HARRY_FOX = 2'd3
    } mapper_type_t;

    // Index of a cartridge block
    // The width follows the block count so that every block can be addressed
    typedef logic [$clog2(`MAPPER_BLOCKS)-1:0] block_id_t;

endpackage

`default_nettype wire

/* design/cart_block_regs.sv */
// Cartridge block configuration registers
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module cart_block_regs (
    input  wire                              cpu_bus,
    input  wire                              rst_n,
    // Configuration write port
    input  wire                              cfg_we,
    input  msx_mapper_pkg::block_id_t        cfg_id,
    input  msx_mapper_pkg::mapper_type_t     cfg_typ,
    input  wire [`MAPPER_ROM_SIZE_W-1:0]     cfg_rom_size,
    // Block that the CPU is currently addressing
    input  msx_mapper_pkg::block_id_t        block_sel,
    // Settings of the selected block
    output msx_mapper_pkg::mapper_type_t     active_typ,
    output logic [`MAPPER_ROM_SIZE_W-1:0]    active_rom_size
);

    import msx_mapper_pkg::*;

    // One entry per cartridge block
    mapper_type_t                  typ_q      [`MAPPER_BLOCKS];
    logic [`MAPPER_ROM_SIZE_W-1:0] rom_size_q [`MAPPER_BLOCKS];

    // Entries come out of reset as unmapped blocks of size zero
    // A write lands on the rising edge and is seen by the read mux one cycle later
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            for (int i = 0; i < `MAPPER_BLOCKS; i++) begin
                typ_q[i]      <= MAPPER_NONE;
                rom_size_q[i] <= '0;
            end
        end else if (cfg_we) begin
            typ_q[cfg_id]      <= cfg_typ;
            rom_size_q[cfg_id] <= cfg_rom_size;
        end
    end

    // Read side is a plain mux on block_sel with no added latency
    assign active_typ      = typ_q[block_sel];
    assign active_rom_size = rom_size_q[block_sel];

    // A configuration write must carry a known mapper kind
    // An unknown type would leave every mapper enable undefined in the top
    cfg_typ_legal_a: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        cfg_we |-> !$isunknown(cfg_typ)
    );

endmodule

`default_nettype wire

/* design/mapper_plain_rom.sv */
// Plain unbanked ROM mapper
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module mapper_plain_rom (
    // Decoded in the top from the active block type
    input  wire                            enable,
    input  wire [`MAPPER_CPU_ADDR_W-1:0]   addr,
    input  wire                            mreq,
    input  wire                            rd,
    input  wire [`MAPPER_ROM_SIZE_W-1:0]   active_rom_size,
    output logic                           ram_cs,
    output logic [`MAPPER_ADDR_W-1:0]      ram_addr
);

    import msx_mapper_pkg::*;

    // Offset of the CPU address from the start of page 1
    logic [`MAPPER_CPU_ADDR_W-1:0] cpu_offset;
    // Linear address before the size check
    logic [`MAPPER_ADDR_W-1:0]     linear_addr;
    // High for pages 1 and 2, which cover 4000h to BFFFh
    logic                          page_mapped;
    logic                          in_range;
    logic                          hit;

    // The ROM starts at 4000h, so page 1 maps to linear 0000h and page 2 to 4000h
    assign cpu_offset  = addr - `MAPPER_CPU_ADDR_W'h4000;
    assign linear_addr = {{(`MAPPER_ADDR_W-`MAPPER_CPU_ADDR_W){1'b0}}, cpu_offset};

    // Pages 0 and 3 stay unmapped
    assign page_mapped = (addr[15:14] == 2'b01) || (addr[15:14] == 2'b10);

    // Reads past the end of the ROM image fall outside the cartridge
    assign in_range = linear_addr <
                      {{(`MAPPER_ADDR_W-`MAPPER_ROM_SIZE_W){1'b0}}, active_rom_size};

    assign hit = enable && mreq && rd && page_mapped && in_range;

    // A miss drives the all-ones address so the memory side sees an idle bus
    assign ram_cs   = hit;
    assign ram_addr = hit ? linear_addr : {`MAPPER_ADDR_W{1'b1}};

endmodule

`default_nettype wire

/* design/mapper_ascii16.sv */
// ASCII16 bank switching mapper
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module mapper_ascii16 (
    input  wire                            cpu_bus,
    input  wire                            rst_n,
    input  wire                            enable,
    input  msx_mapper_pkg::block_id_t      block_sel,
    input  wire [`MAPPER_CPU_ADDR_W-1:0]   addr,
    input  wire [`MAPPER_CPU_DATA_W-1:0]   data,
    input  wire                            mreq,
    input  wire                            rd,
    input  wire                            wr,
    input  wire                            req,
    input  wire [`MAPPER_ROM_SIZE_W-1:0]   active_rom_size,
    output logic                           ram_cs,
    output logic [`MAPPER_ADDR_W-1:0]      ram_addr
);

    import msx_mapper_pkg::*;

    // Bank numbers for the two 16 KB windows, one set per cartridge block
    logic [`MAPPER_CPU_DATA_W-1:0] bank_p1 [`MAPPER_BLOCKS];
    logic [`MAPPER_CPU_DATA_W-1:0] bank_p2 [`MAPPER_BLOCKS];

    logic                          bus_write;
    logic [`MAPPER_CPU_DATA_W-1:0] cur_bank;
    logic                          page_mapped;
    logic [`MAPPER_ADDR_W-1:0]     linear_addr;
    logic                          in_range;
    logic                          hit;

    // A register write needs the mapper enabled and a full memory write cycle
    assign bus_write = enable && mreq && wr && req;

    // Register area for page 1 is 6000h to 67FFh and for page 2 is 7000h to 77FFh
    // Both banks start at 0, so both windows show the first 16 KB after reset
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            for (int i = 0; i < `MAPPER_BLOCKS; i++) begin
                bank_p1[i] <= '0;
                bank_p2[i] <= '0;
            end
        end else if (bus_write) begin
            case (addr[15:11])
                5'b01100: bank_p1[block_sel] <= data;
                5'b01110: bank_p2[block_sel] <= data;
                default:  ;
            endcase
        end
    end

    // Page 1 reads through bank_p1 and page 2 through bank_p2
    always_comb begin
        cur_bank    = '0;
        page_mapped = 1'b0;
        case (addr[15:14])
            2'b01: begin
                cur_bank    = bank_p1[block_sel];
                page_mapped = 1'b1;
            end
            2'b10: begin
                cur_bank    = bank_p2[block_sel];
                page_mapped = 1'b1;
            end
            default: ;
        endcase
    end

    // Bank number selects a 16 KB slice of the ROM image
    assign linear_addr = {{(`MAPPER_ADDR_W-`MAPPER_CPU_DATA_W-14){1'b0}},
                          cur_bank, addr[13:0]};

    assign in_range = linear_addr <
                      {{(`MAPPER_ADDR_W-`MAPPER_ROM_SIZE_W){1'b0}}, active_rom_size};

    assign hit = enable && mreq && rd && page_mapped && in_range;

    assign ram_cs   = hit;
    assign ram_addr = hit ? linear_addr : {`MAPPER_ADDR_W{1'b1}};

    // A memory cycle is either a read or a write
    // Both at once would select the ROM while a bank register is loaded
    rd_wr_exclusive_a: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        mreq |-> !(rd && wr)
    );

endmodule

`default_nettype wire

/* design/mapper_harry_fox.sv */
// Harry Fox bank switching mapper
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module mapper_harry_fox (
    input  wire                            cpu_bus,
    input  wire                            rst_n,
    input  wire                            enable,
    input  msx_mapper_pkg::block_id_t      block_sel,
    input  wire [`MAPPER_CPU_ADDR_W-1:0]   addr,
    input  wire [`MAPPER_CPU_DATA_W-1:0]   data,
    input  wire                            mreq,
    input  wire                            rd,
    input  wire                            wr,
    input  wire                            req,
    input  wire [`MAPPER_ROM_SIZE_W-1:0]   active_rom_size,
    output logic                           ram_cs,
    output logic [`MAPPER_ADDR_W-1:0]      ram_addr
);

    import msx_mapper_pkg::*;

    // Page entry layout is {unmapped, base[1:0]}
    // Base counts in 16 KB units of the ROM image
    localparam logic [2:0] ENTRY_UNMAPPED = 3'b100;
    localparam logic [2:0] ENTRY_BASE0    = 3'b000;
    localparam logic [2:0] ENTRY_BASE1    = 3'b001;

    // Four page entries per cartridge block
    logic [2:0] page_entry [`MAPPER_BLOCKS][4];

    logic                      bus_write;
    logic                      page_unmapped;
    logic [1:0]                page_base;
    logic [`MAPPER_ADDR_W-1:0] linear_addr;
    logic                      in_range;
    logic                      hit;

    assign bus_write = enable && mreq && wr && req;

    // After reset page 1 shows the first 16 KB and page 2 the second
    // The bank bit in data[0] picks which 32 KB half of the ROM both pages use
    // Page 1 always takes the even slice and page 2 the odd one
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            for (int i = 0; i < `MAPPER_BLOCKS; i++) begin
                page_entry[i][0] <= ENTRY_UNMAPPED;
                page_entry[i][1] <= ENTRY_BASE0;
                page_entry[i][2] <= ENTRY_BASE1;
                page_entry[i][3] <= ENTRY_UNMAPPED;
            end
        end else if (bus_write) begin
            case (addr[15:12])
                4'h6: page_entry[block_sel][1] <= {1'b0, data[0], 1'b0};
                4'h7: page_entry[block_sel][2] <= {1'b0, data[0], 1'b1};
                default: ;
            endcase
        end
    end

    // Entry of the page under the current CPU address
    assign {page_unmapped, page_base} = page_entry[block_sel][addr[15:14]];

    // Base selects the 16 KB slice and the low address bits index into it
    assign linear_addr = {{(`MAPPER_ADDR_W-16){1'b0}}, page_base, addr[13:0]};

    assign in_range = linear_addr <
                      {{(`MAPPER_ADDR_W-`MAPPER_ROM_SIZE_W){1'b0}}, active_rom_size};

    assign hit = enable && mreq && rd && !page_unmapped && in_range;

    assign ram_cs   = hit;
    assign ram_addr = hit ? linear_addr : {`MAPPER_ADDR_W{1'b1}};

    // A register write needs a known page decode and a known bank bit
    // Otherwise a page entry would be loaded with an undefined base
    write_known_a: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        bus_write |-> !$isunknown({addr[15:12], data[0]})
    );

endmodule

`default_nettype wire

/* design/cart_mapper_top.sv */
// Cartridge memory mapper top level
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module cart_mapper_top (
    input  wire                            cpu_bus,
    input  wire                            rst_n,
    // CPU bus levels
    input  wire [`MAPPER_CPU_ADDR_W-1:0]   addr,
    input  wire [`MAPPER_CPU_DATA_W-1:0]   data,
    input  wire                            mreq,
    input  wire                            rd,
    input  wire                            wr,
    input  wire                            req,
    input  msx_mapper_pkg::block_id_t      block_sel,
    // Configuration port
    input  wire                            cfg_we,
    input  msx_mapper_pkg::block_id_t      cfg_id,
    input  msx_mapper_pkg::mapper_type_t   cfg_typ,
    input  wire [`MAPPER_ROM_SIZE_W-1:0]   cfg_rom_size,
    // Memory side
    output logic                           ram_cs,
    output logic [`MAPPER_ADDR_W-1:0]      ram_addr
);

    import msx_mapper_pkg::*;

    mapper_type_t                  active_typ;
    logic [`MAPPER_ROM_SIZE_W-1:0] active_rom_size;

    // One enable per mapper, decoded once here from the active type
    logic plain_en;
    logic ascii16_en;
    logic hfox_en;

    logic                      plain_cs;
    logic                      ascii16_cs;
    logic                      hfox_cs;
    logic [`MAPPER_ADDR_W-1:0] plain_addr;
    logic [`MAPPER_ADDR_W-1:0] ascii16_addr;
    logic [`MAPPER_ADDR_W-1:0] hfox_addr;

    cart_block_regs u_block_regs (
        .cpu_bus         (cpu_bus),
        .rst_n           (rst_n),
        .cfg_we          (cfg_we),
        .cfg_id          (cfg_id),
        .cfg_typ         (cfg_typ),
        .cfg_rom_size    (cfg_rom_size),
        .block_sel       (block_sel),
        .active_typ      (active_typ),
        .active_rom_size (active_rom_size)
    );

    assign plain_en   = (active_typ == MAPPER_PLAIN);
    assign ascii16_en = (active_typ == MAPPER_ASCII16);
    assign hfox_en    = (active_typ == MAPPER_HARRY_FOX);

    mapper_plain_rom u_plain (
        .enable          (plain_en),
        .addr            (addr),
        .mreq            (mreq),
        .rd              (rd),
        .active_rom_size (active_rom_size),
        .ram_cs          (plain_cs),
        .ram_addr        (plain_addr)
    );

    mapper_ascii16 u_ascii16 (
        .cpu_bus         (cpu_bus),
        .rst_n           (rst_n),
        .enable          (ascii16_en),
        .block_sel       (block_sel),
        .addr            (addr),
        .data            (data),
        .mreq            (mreq),
        .rd              (rd),
        .wr              (wr),
        .req             (req),
        .active_rom_size (active_rom_size),
        .ram_cs          (ascii16_cs),
        .ram_addr        (ascii16_addr)
    );

    mapper_harry_fox u_harry_fox (
        .cpu_bus         (cpu_bus),
        .rst_n           (rst_n),
        .enable          (hfox_en),
        .block_sel       (block_sel),
        .addr            (addr),
        .data            (data),
        .mreq            (mreq),
        .rd              (rd),
        .wr              (wr),
        .req             (req),
        .active_rom_size (active_rom_size),
        .ram_cs          (hfox_cs),
        .ram_addr        (hfox_addr)
    );

    // Output mux follows the active type so a disabled mapper never reaches the memory
    always_comb begin
        ram_cs   = 1'b0;
        ram_addr = {`MAPPER_ADDR_W{1'b1}};
        case (active_typ)
            MAPPER_PLAIN: begin
                ram_cs   = plain_cs;
                ram_addr = plain_addr;
            end
            MAPPER_ASCII16: begin
                ram_cs   = ascii16_cs;
                ram_addr = ascii16_addr;
            end
            MAPPER_HARRY_FOX: begin
                ram_cs   = hfox_cs;
                ram_addr = hfox_addr;
            end
            default: ;
        endcase
    end

    // The block select steers the configuration mux and every bank register write
    // An unknown select would make the active type and all enables undefined
    block_sel_known_a: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        !$isunknown(block_sel)
    );

endmodule

`default_nettype wire

/* tests/mapper_tb_ref.svh */
// Mapper reference model
`ifndef MAPPER_TB_REF_SVH
`define MAPPER_TB_REF_SVH

// Shadow of the configuration entries, one per cartridge block
mapper_type_t ref_typ  [`MAPPER_BLOCKS];
longint       ref_size [`MAPPER_BLOCKS];

// Shadow ASCII16 banks, index 0 for page 1 and index 1 for page 2
int ref_a16_bank [`MAPPER_BLOCKS][2];

// Shadow Harry Fox page table, kept as a mapped flag and a base in 16 KB units
bit ref_hf_mapped [`MAPPER_BLOCKS][4];
int ref_hf_base   [`MAPPER_BLOCKS][4];

// Every block comes out of reset unconfigured with the reset bank layouts
function automatic void ref_reset();
    for (int b = 0; b < `MAPPER_BLOCKS; b++) begin
        ref_typ[b]          = MAPPER_NONE;
        ref_size[b]         = 0;
        ref_a16_bank[b][0]  = 0;
        ref_a16_bank[b][1]  = 0;
        // Pages 1 and 2 show the first 32 KB, pages 0 and 3 are closed
        ref_hf_mapped[b][0] = 1'b0;
        ref_hf_mapped[b][1] = 1'b1;
        ref_hf_mapped[b][2] = 1'b1;
        ref_hf_mapped[b][3] = 1'b0;
        ref_hf_base[b][0]   = 0;
        ref_hf_base[b][1]   = 0;
        ref_hf_base[b][2]   = 1;
        ref_hf_base[b][3]   = 0;
    end
endfunction

function automatic void ref_cfg(input int id, input mapper_type_t typ, input longint size);
    ref_typ[id]  = typ;
    ref_size[id] = size;
endfunction

// A bank write only counts for the mapper that the addressed block is set to
function automatic void ref_write(input int blk, input int a, input int d,
                                  input bit m, input bit w, input bit q);
    if (m && w && q) begin
        if (ref_typ[blk] == MAPPER_ASCII16) begin
            if (a >= 'h6000 && a <= 'h67FF)
                ref_a16_bank[blk][0] = d % 256;
            else if (a >= 'h7000 && a <= 'h77FF)
                ref_a16_bank[blk][1] = d % 256;
        end else if (ref_typ[blk] == MAPPER_HARRY_FOX) begin
            // The low data bit picks the 32 KB half and the page picks the 16 KB slice in it
            if (a / 'h1000 == 6)
                ref_hf_base[blk][1] = 2 * (d % 2);
            else if (a / 'h1000 == 7)
                ref_hf_base[blk][2] = 2 * (d % 2) + 1;
        end
    end
endfunction

// Returns {ram_cs, ram_addr} as the memory side should see them for a CPU access
function automatic logic [`MAPPER_ADDR_W:0] expected_map(input int blk, input int a,
                                                         input bit m, input bit r);
    longint lin;
    bit     mapped;
    int     page;
    page   = a / 'h4000;
    lin    = 0;
    mapped = 1'b0;
    if (m && r) begin
        case (ref_typ[blk])
            MAPPER_PLAIN: begin
                mapped = (page == 1) || (page == 2);
                lin    = a - 'h4000;
            end
            MAPPER_ASCII16: begin
                mapped = (page == 1) || (page == 2);
                if (mapped)
                    lin = longint'(ref_a16_bank[blk][page - 1]) * 'h4000 + a % 'h4000;
            end
            MAPPER_HARRY_FOX: begin
                mapped = ref_hf_mapped[blk][page];
                lin    = longint'(ref_hf_base[blk][page]) * 'h4000 + a % 'h4000;
            end
            default: mapped = 1'b0;
        endcase
    end
    // A miss leaves the select low and parks the address at all ones
    if (mapped && lin < ref_size[blk])
        return {1'b1, lin[`MAPPER_ADDR_W-1:0]};
    return {1'b0, {`MAPPER_ADDR_W{1'b1}}};
endfunction

`endif

/* tests/mapper_tb.sv */
// Cartridge mapper testbench
`default_nettype none
`timescale 1ns/1ps

`include "msx_mapper_cfg.svh"

module mapper_tb;

    import msx_mapper_pkg::*;

    // Iterations per test loop
    localparam int N_ITER = 125;
    // Each iteration costs at most about 20 cycles summed over the five tests
    localparam int EST_CYCLES  = 20 * N_ITER;
    localparam int CYCLE_LIMIT = EST_CYCLES * 8 / 5;

    logic                          cpu_bus;
    logic                          rst_n;
    logic [`MAPPER_CPU_ADDR_W-1:0] addr;
    logic [`MAPPER_CPU_DATA_W-1:0] data;
    logic                          mreq;
    logic                          rd;
    logic                          wr;
    logic                          req;
    block_id_t                     block_sel;
    logic                          cfg_we;
    block_id_t                     cfg_id;
    mapper_type_t                  cfg_typ;
    logic [`MAPPER_ROM_SIZE_W-1:0] cfg_rom_size;
    logic                          ram_cs;
    logic [`MAPPER_ADDR_W-1:0]     ram_addr;

    integer                        seed;
    logic [31:0]                   rnd;
    logic [`MAPPER_ADDR_W:0]       exp_map;
    bit                            check_en;
    int                            cycle_count;
    int                            total_checks;
    int                            total_errors;
    int                            test_checks;
    int                            test_errors;
    int                            test_num;

    `include "mapper_tb_ref.svh"

    cart_mapper_top uut (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .addr         (addr),
        .data         (data),
        .mreq         (mreq),
        .rd           (rd),
        .wr           (wr),
        .req          (req),
        .block_sel    (block_sel),
        .cfg_we       (cfg_we),
        .cfg_id       (cfg_id),
        .cfg_typ      (cfg_typ),
        .cfg_rom_size (cfg_rom_size),
        .ram_cs       (ram_cs),
        .ram_addr     (ram_addr)
    );

    always #50 cpu_bus = ~cpu_bus;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        total_checks++;
        test_checks++;
        if (got !== expv) begin
            total_errors++;
            test_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expv);
        end
    endtask

    // Outputs are settled by the falling edge, half a period after the inputs moved
    always @(negedge cpu_bus) begin
        if (check_en) begin
            exp_map = expected_map(block_sel, addr, mreq, rd);
            check_value("ram_cs", ram_cs, exp_map[`MAPPER_ADDR_W]);
            check_value("ram_addr", ram_addr, exp_map[`MAPPER_ADDR_W-1:0]);
        end
    end

    always @(posedge cpu_bus) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // Every bus task starts just after a rising edge and ends on the next one
    task automatic apply_cfg(input block_id_t id, input mapper_type_t typ,
                             input logic [`MAPPER_ROM_SIZE_W-1:0] size);
        #5;
        cfg_we       = 1'b1;
        cfg_id       = id;
        cfg_typ      = typ;
        cfg_rom_size = size;
        mreq         = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        req          = 1'b0;
        @(posedge cpu_bus);
        ref_cfg(id, typ, size);
    endtask

    task automatic cpu_write(input block_id_t blk, input logic [15:0] a,
                             input logic [7:0] d, input logic m, input logic q);
        #5;
        cfg_we    = 1'b0;
        block_sel = blk;
        addr      = a;
        data      = d;
        mreq      = m;
        rd        = 1'b0;
        wr        = 1'b1;
        req       = q;
        @(posedge cpu_bus);
        ref_write(blk, a, d, m, 1'b1, q);
    endtask

    task automatic cpu_read(input block_id_t blk, input logic [15:0] a);
        #5;
        cfg_we    = 1'b0;
        block_sel = blk;
        addr      = a;
        mreq      = 1'b1;
        rd        = 1'b1;
        wr        = 1'b0;
        req       = 1'b1;
        @(posedge cpu_bus);
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %0d checks, %0d errors", test_num, name, test_checks,
                 test_errors);
        test_num++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Unconfigured reads first, then the Harry Fox reset layout page by page
    task automatic test_reset_layout();
        for (int i = 0; i < N_ITER; i++) begin
            rnd = $random(seed);
            cpu_read(rnd[16], rnd[15:0]);
        end
        apply_cfg(1'b0, MAPPER_HARRY_FOX, 25'h10000);
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < N_ITER / 4; i++) begin
                rnd = $random(seed);
                cpu_read(1'b0, {p[1:0], rnd[13:0]});
            end
        end
        end_test("reset state and Harry Fox layout");
    endtask

    task automatic test_hfox_switch();
        logic [15:0] a;
        for (int i = 0; i < N_ITER; i++) begin
            rnd = $random(seed);
            a   = rnd[20] ? {4'h7, rnd[11:0]} : {4'h6, rnd[11:0]};
            cpu_write(1'b0, a, rnd[31:24], 1'b1, 1'b1);
            // Read every page so a write that leaks into the other page shows up
            for (int p = 0; p < 4; p++) begin
                rnd = $random(seed);
                cpu_read(1'b0, {p[1:0], rnd[13:0]});
            end
        end
        end_test("Harry Fox bank switching");
    endtask

    task automatic test_ascii16_banks();
        logic [15:0] a;
        // A 2 MB image puts banks 80h and up past the end of the ROM
        apply_cfg(1'b0, MAPPER_ASCII16, 25'h200000);
        for (int i = 0; i < N_ITER; i++) begin
            rnd = $random(seed);
            case (rnd[21:20])
                2'd0:    a = {5'b01100, rnd[10:0]};
                2'd1:    a = {5'b01110, rnd[10:0]};
                2'd2:    a = {5'b01101, rnd[10:0]};
                default: a = {5'b01111, rnd[10:0]};
            endcase
            cpu_write(1'b0, a, rnd[31:24], 1'b1, 1'b1);
            rnd = $random(seed);
            cpu_read(1'b0, {2'b01, rnd[13:0]});
            cpu_read(1'b0, {2'b10, rnd[29:16]});
            rnd = $random(seed);
            cpu_read(1'b0, rnd[15:0]);
        end
        end_test("ASCII16 bank switching");
    endtask

    task automatic test_plain_rom();
        logic [`MAPPER_ROM_SIZE_W-1:0] sizes [4];
        sizes[0] = 25'h8000;
        sizes[1] = 25'h4000;
        sizes[2] = 25'h5A00;
        sizes[3] = 25'h10000;
        for (int s = 0; s < 4; s++) begin
            apply_cfg(1'b0, MAPPER_PLAIN, sizes[s]);
            cpu_read(1'b0, 16'h4000);
            cpu_read(1'b0, 16'hBFFF);
            for (int i = 0; i < N_ITER; i++) begin
                rnd = $random(seed);
                cpu_read(1'b0, rnd[15:0]);
            end
        end
        end_test("plain ROM mapping");
    endtask

    // Block 0 runs ASCII16 and block 1 Harry Fox, each with its own bank state
    task automatic test_two_blocks();
        logic [15:0] a;
        apply_cfg(1'b0, MAPPER_ASCII16, 25'h400000);
        apply_cfg(1'b1, MAPPER_HARRY_FOX, 25'h10000);
        for (int i = 0; i < N_ITER; i++) begin
            rnd = $random(seed);
            a   = {3'b011, rnd[1], rnd[13:2]};
            // About one write in four has mreq low and one in four has req low
            cpu_write(rnd[0], a, rnd[31:24], rnd[14] | rnd[15], rnd[16] | rnd[17]);
            rnd = $random(seed);
            cpu_read(1'b0, {rnd[0] ? 2'b10 : 2'b01, rnd[15:2]});
            cpu_read(1'b1, {rnd[16] ? 2'b10 : 2'b01, rnd[31:18]});
        end
        end_test("independent blocks");
    endtask

    initial begin
        seed         = 10100;
        cpu_bus      = 1'b0;
        rst_n        = 1'b0;
        addr         = '0;
        data         = '0;
        mreq         = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        req          = 1'b0;
        block_sel    = 1'b0;
        cfg_we       = 1'b0;
        cfg_id       = 1'b0;
        cfg_typ      = MAPPER_NONE;
        cfg_rom_size = '0;
        check_en     = 1'b0;
        cycle_count  = 0;
        total_checks = 0;
        total_errors = 0;
        test_checks  = 0;
        test_errors  = 0;
        test_num     = 1;
        ref_reset();

        repeat (3) @(posedge cpu_bus);
        #5;
        rst_n = 1'b1;
        @(posedge cpu_bus);
        check_en = 1'b1;

        test_reset_layout();
        test_hfox_switch();
        test_ascii16_banks();
        test_plain_rom();
        test_two_blocks();

        check_en = 1'b0;
        $display("Checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
+incdir+tests
design/msx_mapper_pkg.sv
design/cart_block_regs.sv
design/mapper_plain_rom.sv
design/mapper_ascii16.sv
design/mapper_harry_fox.sv
design/cart_mapper_top.sv
tests/mapper_tb.sv
